// File: hdl/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // ==================================================
    // Address split and line size
    // ==================================================
    localparam int ADDR_W  = 32;   // Byte address
    localparam int LINE_W  = 128;  // Four 32-bit words per line
    localparam int INDEX_W = 8;    // Set index, address bits 11..4
    localparam int TAG_W   = 20;   // Tag, address bits 31..12

    // Typed vectors
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [TAG_W:0]     tag_entry_t;  // Valid flag in the top bit

    // ==================================================
    // Controller FSM
    // ==================================================
    typedef enum logic [2:0]
    {
        INIT,         // Tag clear sweep after reset or flush
        IDLE,         // Lookup
        FILL,         // Waiting on memory
        FILL_DONE,    // Line written this cycle
        TURN_AROUND   // Re-read of the RAMs
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/icache_way_if.sv
`timescale 1ns/100ps
`default_nettype none

interface icache_way_if #(
    parameter int WAYS = 4
) ();
    import icache_pkg::*;

    // Controller side
    index_t          o_index;    // Set read or written
    logic [WAYS-1:0] tag_we;     // Per-way tag write
    logic [WAYS-1:0] data_we;    // Per-way line write
    tag_entry_t      tag_wdata;  // Cleared entry or fill tag

    // Way array side, one cycle after o_index
    logic [WAYS-1:0] hit;
    logic [WAYS-1:0] valid;

    modport ctrl
    (
        output o_index,
        output tag_we,
        output data_we,
        output tag_wdata,
        input  hit,
        input  valid
    );

    modport ways
    (
        input  o_index,
        input  tag_we,
        input  data_we,
        input  tag_wdata,
        output hit,
        output valid
    );

endinterface

`default_nettype wire

// File: hdl/icache_sp_ram.sv
`timescale 1ns/100ps
`default_nettype none

module icache_sp_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 256
) (
    input  wire                     i_clk,
    input  wire                     i_we,
    input  wire [$clog2(DEPTH)-1:0] i_addr,
    input  wire [WIDTH-1:0]         i_wdata,
    output logic [WIDTH-1:0]        o_rdata
);

    logic [WIDTH-1:0] mem [DEPTH];  // Storage array

    // Single port, write and registered read share the address
    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];  // Old contents on a write cycle
    end

endmodule

`default_nettype wire

// File: hdl/icache_ways.sv
`timescale 1ns/100ps
`default_nettype none

module icache_ways #(
    parameter int WAYS = 4
) (
    input  wire                i_clk,
    input  wire icache_pkg::addr_t i_address,   // Core address, tag compared here
    input  wire icache_pkg::line_t i_wb_data,   // Fill line straight from memory
    output icache_pkg::line_t  o_hit_line,
    icache_way_if.ways         way
);
    import icache_pkg::*;

    localparam int DEPTH = 2 ** INDEX_W;  // One entry per set

    tag_entry_t      tag_rdata  [WAYS];  // Registered tag reads
    line_t           data_rdata [WAYS];  // Registered line reads
    tag_t            addr_tag;
    logic [WAYS-1:0] hit_vec;
    logic [WAYS-1:0] valid_vec;

    assign addr_tag = i_address[ADDR_W-1 -: TAG_W];

    // ==================================================
    // Tag and data RAM per way
    // ==================================================
    for (genvar w = 0; w < WAYS; w++)
    begin : g_way
        icache_sp_ram #(
            .WIDTH (TAG_W + 1),
            .DEPTH (DEPTH)
        ) tag_ram_i (
            .i_clk   (i_clk),
            .i_we    (way.tag_we[w]),
            .i_addr  (way.o_index),
            .i_wdata (way.tag_wdata),  // Same entry to every enabled way
            .o_rdata (tag_rdata[w])
        );

        icache_sp_ram #(
            .WIDTH (LINE_W),
            .DEPTH (DEPTH)
        ) data_ram_i (
            .i_clk   (i_clk),
            .i_we    (way.data_we[w]),
            .i_addr  (way.o_index),
            .i_wdata (i_wb_data),      // Read-only cache, fill is the only writer
            .o_rdata (data_rdata[w])
        );
    end

    // ==================================================
    // Compare and line select
    // ==================================================
    always_comb
    begin
        valid_vec  = '0;
        hit_vec    = '0;
        o_hit_line = '0;
        for (int i = 0; i < WAYS; i++)
        begin
            valid_vec[i] = tag_rdata[i][TAG_W];
            // Valid entry with matching tag
            hit_vec[i] = tag_rdata[i][TAG_W] && (tag_rdata[i][TAG_W-1:0] == addr_tag);
            if (hit_vec[i])
            begin
                o_hit_line = o_hit_line | data_rdata[i];  // At most one way hits
            end
        end
    end

    assign way.hit   = hit_vec;
    assign way.valid = valid_vec;

endmodule

`default_nettype wire

// File: hdl/icache_victim_sel.sv
`timescale 1ns/100ps
`default_nettype none

module icache_victim_sel #(
    parameter int WAYS = 4
) (
    input  wire              i_clk,
    input  wire              i_rst_n,
    input  wire              i_step,     // High for each FILL cycle
    input  wire [WAYS-1:0]   i_valid,    // Valid bits of the miss set
    output logic [WAYS-1:0]  o_way       // One-hot victim
);

    localparam int SEL_W = (WAYS > 1) ? $clog2(WAYS) : 1;

    logic [3:0]       lfsr;
    logic [SEL_W-1:0] rnd_sel;
    logic             found;

    // 4-bit LFSR, x^4 + x^3 + 1
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            lfsr <= 4'hf;
        else if (i_step)
            lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
    end

    assign rnd_sel = SEL_W'(lfsr % WAYS);

    // Lowest invalid way wins, else random
    always_comb
    begin
        o_way = '0;
        found = 1'b0;
        for (int i = 0; i < WAYS; i++)
        begin
            if (!i_valid[i] && !found)
            begin
                o_way[i] = 1'b1;
                found    = 1'b1;
            end
        end
        if (!found)
            o_way[rnd_sel] = 1'b1;  // Set full
    end

endmodule

`default_nettype wire

// File: hdl/icache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl #(
    parameter int WAYS = 4
) (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_select,
    input  wire icache_pkg::addr_t i_address,
    input  wire                    i_cache_enable,
    input  wire                    i_cache_flush,
    input  wire                    i_wb_ready,
    input  wire                    i_buf_hit,     // Read buffer serves this address
    output logic                   o_stall,
    output logic                   o_wb_req,
    output icache_pkg::addr_t      o_wb_addr,
    output logic                   o_fill_done,
    icache_way_if.ctrl             way
);
    import icache_pkg::*;

    localparam int OFS_W = ADDR_W - TAG_W - INDEX_W;  // Byte offset bits in a line

    ctrl_state_t     state;
    index_t          init_count;    // Set being cleared
    addr_t           address_r;     // Address the RAMs were read with
    addr_t           miss_addr;
    addr_t           wb_src;
    logic            enable;
    logic            invalid_read;
    logic            lookup_hit;
    logic            read_miss;
    logic [WAYS-1:0] victim;

    // ==================================================
    // Lookup decode
    // ==================================================
    assign enable       = i_select && i_cache_enable;
    assign invalid_read = address_r != i_address;  // RAM output belongs to an older address
    assign lookup_hit   = (state == IDLE) && !invalid_read && (|way.hit);
    assign read_miss    = enable && (state == IDLE) && !invalid_read
                          && !(|way.hit) && !i_buf_hit;

    assign o_wb_req    = read_miss;                      // Single cycle, state leaves IDLE
    assign o_fill_done = (state == FILL) && i_wb_ready;  // Line arrives, forwarded as well

    // Live address in the request cycle, captured one during the fill
    assign wb_src    = (state == IDLE) ? i_address : miss_addr;
    assign o_wb_addr = {wb_src[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};

    // INIT always stalls, otherwise only an unserved enabled read
    assign o_stall = (state == INIT)
                     || (enable && !lookup_hit && !o_fill_done && !i_buf_hit);

    // ==================================================
    // RAM controls
    // ==================================================
    always_comb
    begin
        if (state == INIT)
            way.o_index = init_count;                           // Clear sweep
        else if (state == FILL)
            way.o_index = miss_addr[OFS_W +: INDEX_W];          // Victim set
        else
            way.o_index = i_address[OFS_W +: INDEX_W];          // Normal lookup
    end

    assign way.tag_we    = (state == INIT) ? {WAYS{1'b1}} : (o_fill_done ? victim : '0);
    assign way.data_we   = o_fill_done ? victim : '0;
    assign way.tag_wdata = (state == INIT) ? '0 : {1'b1, miss_addr[ADDR_W-1 -: TAG_W]};

    icache_victim_sel #(
        .WAYS (WAYS)
    ) victim_sel_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_step  (state == FILL),
        .i_valid (way.valid),   // Miss set, read in IDLE and FILL
        .o_way   (victim)
    );

    // ==================================================
    // State machine
    // ==================================================
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_cache_flush)
        begin
            state      <= INIT;
            init_count <= '0;
        end
        else
        begin
            case (state)
                INIT:
                begin
                    init_count <= init_count + 1'b1;
                    if (init_count == '1)
                        state <= TURN_AROUND;  // Last set cleared
                end
                IDLE:
                    if (read_miss)
                        state <= FILL;
                FILL:
                    if (i_wb_ready)
                        state <= FILL_DONE;
                FILL_DONE:
                    state <= TURN_AROUND;
                TURN_AROUND:
                    state <= IDLE;             // RAMs now hold a fresh read
                default:
                    state <= INIT;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            address_r <= '0;
        else
            address_r <= i_address;
    end

    // Miss address, held through the fill
    always_ff @(posedge i_clk)
    begin
        if (read_miss)
            miss_addr <= i_address;
    end

endmodule

`default_nettype wire

// File: hdl/icache_read_buf.sv
`timescale 1ns/100ps
`default_nettype none

module icache_read_buf (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_cache_flush,
    input  wire                    i_fill_done,
    input  wire                    i_wb_req,
    input  wire icache_pkg::addr_t i_miss_addr,   // Line address of the fill
    input  wire icache_pkg::addr_t i_address,
    input  wire icache_pkg::line_t i_wb_data,
    input  wire icache_pkg::line_t i_hit_line,
    output logic                   o_buf_hit,
    output icache_pkg::line_t      o_read_data
);
    import icache_pkg::*;

    localparam int OFS_W = ADDR_W - TAG_W - INDEX_W;

    line_t                  buf_data;
    logic [ADDR_W-1:OFS_W]  buf_line;   // Line address only
    logic                   buf_valid;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_cache_flush)
            buf_valid <= 1'b0;
        else if (i_fill_done)
            buf_valid <= 1'b1;
        else if (i_wb_req)
            buf_valid <= 1'b0;  // Next fill on its way
    end

    always_ff @(posedge i_clk)
    begin
        if (i_fill_done)
        begin
            buf_data <= i_wb_data;
            buf_line <= i_miss_addr[ADDR_W-1:OFS_W];
        end
    end

    assign o_buf_hit = buf_valid && (i_address[ADDR_W-1:OFS_W] == buf_line);

    // Forwarded fill first, then buffer, then RAM
    assign o_read_data = i_fill_done ? i_wb_data :
                         o_buf_hit   ? buf_data  :
                                       i_hit_line;

endmodule

`default_nettype wire

// File: hdl/icache_top.sv
`timescale 1ns/100ps
`default_nettype none

module icache_top #(
    parameter int WAYS = 4
) (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    // Core side
    input  wire                    i_select,
    input  wire icache_pkg::addr_t i_address,
    input  wire                    i_cache_enable,
    input  wire                    i_cache_flush,
    output icache_pkg::line_t      o_read_data,
    output logic                   o_stall,
    // Memory side
    output logic                   o_wb_req,
    output icache_pkg::addr_t      o_wb_addr,
    input  wire icache_pkg::line_t i_wb_data,
    input  wire                    i_wb_ready
);
    import icache_pkg::*;

    line_t hit_line;    // Line from the hitting way
    logic  buf_hit;
    logic  fill_done;

    icache_way_if #(.WAYS(WAYS)) way_if ();

    // ==================================================
    // Controller, way array, read buffer
    // ==================================================
    icache_ctrl #(
        .WAYS (WAYS)
    ) ctrl_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_select       (i_select),
        .i_address      (i_address),
        .i_cache_enable (i_cache_enable),
        .i_cache_flush  (i_cache_flush),
        .i_wb_ready     (i_wb_ready),
        .i_buf_hit      (buf_hit),
        .o_stall        (o_stall),
        .o_wb_req       (o_wb_req),
        .o_wb_addr      (o_wb_addr),
        .o_fill_done    (fill_done),
        .way            (way_if.ctrl)
    );

    icache_ways #(
        .WAYS (WAYS)
    ) ways_i (
        .i_clk      (i_clk),
        .i_address  (i_address),
        .i_wb_data  (i_wb_data),
        .o_hit_line (hit_line),
        .way        (way_if.ways)
    );

    icache_read_buf read_buf_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_cache_flush (i_cache_flush),
        .i_fill_done   (fill_done),
        .i_wb_req      (o_wb_req),
        .i_miss_addr   (o_wb_addr),  // Holds the line address through the fill
        .i_address     (i_address),
        .i_wb_data     (i_wb_data),
        .i_hit_line    (hit_line),
        .o_buf_hit     (buf_hit),
        .o_read_data   (o_read_data)
    );

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;  // Free running
    end

    // Low for RESET_CYCLES rising edges, released on a falling edge
    initial
    begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/icache_props.sv
`timescale 1ns/100ps
`default_nettype none

module icache_props (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire                     i_cache_flush,
    input  icache_pkg::ctrl_state_t i_state,
    input  wire                     i_wb_req,
    input  wire                     i_wb_ready,
    input  wire                     i_stall
);
    import icache_pkg::*;

    localparam int SWEEP_LEN = 1 << INDEX_W;  // One INIT cycle per set

    logic fill_open;   // High from request until the line is back
    int   sweep_left;  // Init sweep cycles still to come

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            fill_open <= 1'b0;
        else if (i_wb_req)
            fill_open <= 1'b1;
        else if (i_wb_ready)
            fill_open <= 1'b0;  // Line delivered
    end

    // Reset or flush starts a full sweep
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_cache_flush)
            sweep_left <= SWEEP_LEN;
        else if (sweep_left > 0)
            sweep_left <= sweep_left - 1;
    end

    // ==================================================
    // Memory request protocol
    // ==================================================
    a_req_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_req |=> !i_wb_req)
        else $error("o_wb_req high on two consecutive cycles");

    a_one_outstanding: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        fill_open |-> !i_wb_req)
        else $error("new o_wb_req issued before i_wb_ready of the previous one");

    // Init sweep holds the core off
    a_init_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (sweep_left > 0) |-> ((i_state == INIT) && i_stall))
        else $error("o_stall low or state not INIT during the init sweep");

    a_init_length: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_state == INIT) |-> (sweep_left > 0))
        else $error("INIT lasted longer than one cycle per set");

endmodule

`default_nettype wire

// File: tests/tb_icache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_icache;
    import icache_pkg::*;

    localparam int SAMPLE_DLY   = 4;              // Sample point 1 ns before the rising edge
    localparam int READ_TIMEOUT = 40;
    localparam int INIT_TIMEOUT = 400;
    localparam int SWEEP_CYCLES = 1 << INDEX_W;  // One INIT cycle per set
    localparam int REQ_NONE     = 0;
    localparam int REQ_ONE      = 1;
    localparam int REQ_ANY      = 2;              // Eviction with an LFSR-picked victim

    logic  i_clk;
    logic  i_rst_n;
    logic  i_select;
    addr_t i_address;
    logic  i_cache_enable;
    logic  i_cache_flush;
    line_t i_wb_data;
    logic  i_wb_ready;
    line_t o_read_data;
    logic  o_stall;
    logic  o_wb_req;
    addr_t o_wb_addr;

    // Stimulus table with one entry per row in each queue
    string row_name  [$];
    addr_t row_addr  [$];
    bit    row_en    [$];
    bit    row_flush [$];
    int    row_req   [$];

    logic [16:0] lfsr_state;    // Memory latency source
    int          req_count;
    addr_t       req_addr;      // o_wb_addr of the last request
    addr_t       fill_addr;
    int          fill_wait;     // Cycles to i_wb_ready or 0 when idle
    int          checks;
    int          value_errs;
    int          protocol_errs;
    int          other_errs;
    bit          timed_out;

    tb_clk_gen #(
        .PERIOD       (10),
        .RESET_CYCLES (3)
    ) clk_gen_i (
        .o_clk   (i_clk),
        .o_rst_n (i_rst_n)
    );

    icache_top #(
        .WAYS (4)
    ) dut_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_select       (i_select),
        .i_address      (i_address),
        .i_cache_enable (i_cache_enable),
        .i_cache_flush  (i_cache_flush),
        .o_read_data    (o_read_data),
        .o_stall        (o_stall),
        .o_wb_req       (o_wb_req),
        .o_wb_addr      (o_wb_addr),
        .i_wb_data      (i_wb_data),
        .i_wb_ready     (i_wb_ready)
    );

    bind icache_ctrl icache_props props_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_cache_flush (i_cache_flush),
        .i_state       (state),
        .i_wb_req      (o_wb_req),
        .i_wb_ready    (i_wb_ready),
        .i_stall       (o_stall)
    );

    // ==================================================
    // Helpers
    // ==================================================
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};  // x^17 + x^14 + 1
    endfunction

    // Line contents as a function of the line address only
    function automatic line_t model_line(input addr_t a);
        addr_t base;
        base = {a[ADDR_W-1:4], 4'h0};
        return {base ^ 32'h5a5a_0003, base ^ 32'h5a5a_0002,
                base ^ 32'h5a5a_0001, base ^ 32'h5a5a_0000};
    endfunction

    task automatic add_row(input string name, input addr_t addr, input bit en,
                           input bit flush, input int req);
        row_name.push_back(name);
        row_addr.push_back(addr);
        row_en.push_back(en);
        row_flush.push_back(flush);
        row_req.push_back(req);
    endtask

    task automatic check_value(input string name, input logic [LINE_W-1:0] exp,
                               input logic [LINE_W-1:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("Fail %s: expected %0h, actual %0h", name, exp, act);
            value_errs++;
        end
    endtask

    // Starts and ends at a sample point
    task automatic wait_stall_low(input string name, input int limit, output int stalled);
        stalled = 0;
        while (o_stall === 1'b1 && stalled < limit)
        begin
            @(negedge i_clk);
            #(SAMPLE_DLY);
            stalled++;
        end
        if (o_stall !== 1'b0)
        begin
            $display("Timeout in %s: o_stall still high after %0d cycles", name, stalled);
            other_errs++;
            timed_out = 1'b1;
        end
    endtask

    // ==================================================
    // Memory model
    // ==================================================
    initial
    begin
        logic [2:0] pick;
        i_wb_ready    = 1'b0;
        i_wb_data     = '0;
        lfsr_state    = 17'd99479;
        req_count     = 0;
        req_addr      = '0;
        fill_addr     = '0;
        fill_wait     = 0;
        protocol_errs = 0;
        forever
        begin
            @(negedge i_clk);
            i_wb_ready = 1'b0;
            i_wb_data  = '0;
            if (fill_wait > 0)
            begin
                fill_wait--;
                if (fill_wait == 0)
                begin
                    i_wb_ready = 1'b1;              // Single ready pulse with the line
                    i_wb_data  = model_line(fill_addr);
                end
            end
            #(SAMPLE_DLY);
            if (o_wb_req === 1'b1)
            begin
                req_count++;
                req_addr = o_wb_addr;
                if (fill_wait > 0)
                begin
                    $display("Memory got a request while a fill was still pending");
                    protocol_errs++;
                end
                fill_addr = o_wb_addr;
                for (int b = 0; b < 3; b++)
                begin
                    lfsr_state = lfsr_step(lfsr_state);
                    pick       = {pick[1:0], lfsr_state[0]};
                end
                fill_wait = 1 + int'(pick) % 6;     // 1 to 6 cycles
            end
        end
    end

    // ==================================================
    // Stimulus and checks
    // ==================================================
    initial
    begin
        int    cycles;
        int    start_reqs;
        int    delta;
        addr_t line_addr;
        i_select       = 1'b0;
        i_address      = '0;
        i_cache_enable = 1'b1;
        i_cache_flush  = 1'b0;
        checks         = 0;
        value_errs     = 0;
        other_errs     = 0;
        timed_out      = 1'b0;

        add_row("cold_miss",        32'h0000_0048, 1'b1, 1'b0, REQ_ONE);
        add_row("repeat_hit",       32'h0000_004c, 1'b1, 1'b0, REQ_NONE);
        add_row("fill_way0",        32'h0000_1100, 1'b1, 1'b0, REQ_ONE);   // Set 0x10
        add_row("fill_way1",        32'h0000_2104, 1'b1, 1'b0, REQ_ONE);
        add_row("fill_way2",        32'h0000_3108, 1'b1, 1'b0, REQ_ONE);
        add_row("fill_way3",        32'h0000_410c, 1'b1, 1'b0, REQ_ONE);
        add_row("hit_way0",         32'h0000_1100, 1'b1, 1'b0, REQ_NONE);
        add_row("hit_way1",         32'h0000_2100, 1'b1, 1'b0, REQ_NONE);
        add_row("hit_way2",         32'h0000_3100, 1'b1, 1'b0, REQ_NONE);
        add_row("hit_way3",         32'h0000_4100, 1'b1, 1'b0, REQ_NONE);
        add_row("old_line_hit",     32'h0000_0040, 1'b1, 1'b0, REQ_NONE);
        add_row("evict_miss",       32'h0000_5100, 1'b1, 1'b0, REQ_ONE);   // Fifth tag
        add_row("reread_tag1",      32'h0000_1100, 1'b1, 1'b0, REQ_ANY);
        add_row("reread_tag2",      32'h0000_2100, 1'b1, 1'b0, REQ_ANY);
        add_row("reread_tag3",      32'h0000_3100, 1'b1, 1'b0, REQ_ANY);
        add_row("reread_tag4",      32'h0000_4100, 1'b1, 1'b0, REQ_ANY);
        add_row("reread_tag5",      32'h0000_5100, 1'b1, 1'b0, REQ_ANY);
        add_row("flush_sweep",      32'h0000_0000, 1'b1, 1'b1, REQ_NONE);
        add_row("after_flush_miss", 32'h0000_0044, 1'b1, 1'b0, REQ_ONE);
        add_row("after_flush_hit",  32'h0000_0048, 1'b1, 1'b0, REQ_NONE);
        add_row("disabled_a",       32'h0000_9000, 1'b0, 1'b0, REQ_NONE);
        add_row("disabled_b",       32'h0000_0040, 1'b0, 1'b0, REQ_NONE);
        add_row("enabled_again",    32'h0000_9000, 1'b1, 1'b0, REQ_ONE);

        // Reset release and the first init sweep
        cycles = 0;
        while (i_rst_n !== 1'b1 && cycles < INIT_TIMEOUT)
        begin
            @(negedge i_clk);
            #(SAMPLE_DLY);
            cycles++;
        end
        if (i_rst_n !== 1'b1)
        begin
            $display("Timeout: reset was never released");
            other_errs++;
            timed_out = 1'b1;
        end
        else
        begin
            wait_stall_low("reset_sweep", INIT_TIMEOUT, cycles);
            check_value("reset_no_req", '0, LINE_W'(req_count));
        end

        for (int r = 0; r < row_name.size() && !timed_out; r++)
        begin
            @(negedge i_clk);
            if (row_flush[r])
            begin
                i_select      = 1'b0;
                i_cache_flush = 1'b1;
                @(negedge i_clk);
                i_cache_flush = 1'b0;
                #(SAMPLE_DLY);
                wait_stall_low(row_name[r], INIT_TIMEOUT, cycles);  // Counts INIT cycles
                if (!timed_out)
                    check_value(row_name[r], LINE_W'(SWEEP_CYCLES), LINE_W'(cycles));
            end
            else
            begin
                i_select       = 1'b1;
                i_address      = row_addr[r];
                i_cache_enable = row_en[r];
                start_reqs     = req_count;
                line_addr      = {row_addr[r][ADDR_W-1:4], 4'h0};
                #(SAMPLE_DLY);
                if (!row_en[r])
                begin
                    // Bypass observes only stall and request
                    for (int c = 0; c < 3; c++)
                    begin
                        check_value({row_name[r], " stall"}, '0, LINE_W'(o_stall));
                        @(negedge i_clk);
                        #(SAMPLE_DLY);
                    end
                end
                else
                begin
                    wait_stall_low(row_name[r], READ_TIMEOUT, cycles);
                    if (!timed_out)
                        check_value(row_name[r], model_line(row_addr[r]), o_read_data);
                end
                delta = req_count - start_reqs;
                if (!timed_out && row_req[r] == REQ_ONE)
                begin
                    check_value({row_name[r], " requests"}, LINE_W'(1), LINE_W'(delta));
                    check_value({row_name[r], " o_wb_addr"}, LINE_W'(line_addr),
                                LINE_W'(req_addr));
                end
                else if (!timed_out && row_req[r] == REQ_NONE)
                begin
                    check_value({row_name[r], " requests"}, '0, LINE_W'(delta));
                end
            end
        end

        @(negedge i_clk);
        i_select = 1'b0;
        $display("Summary: %0d checks, %0d value errors, %0d protocol errors, %0d other errors",
                 checks, value_errs, protocol_errs, other_errs);
        if (value_errs == 0 && protocol_errs == 0 && other_errs == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hdl/icache_pkg.sv
hdl/icache_way_if.sv
hdl/icache_sp_ram.sv
hdl/icache_ways.sv
hdl/icache_victim_sel.sv
hdl/icache_ctrl.sv
hdl/icache_read_buf.sv
hdl/icache_top.sv
tests/tb_clk_gen.sv
tests/icache_props.sv
tests/tb_icache.sv

// File: run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_icache -f project.f

# Result comes from the printed message, a stopped run never passes
out=$(./obj_dir/Vtb_icache || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'
then
    exit 0
fi
exit 1
